// ==== sim.f ====
verilog/procPkg.sv
verilog/stageIf.sv
verilog/fetch.sv
verilog/decode.sv
verilog/execute.sv
verilog/memory.sv
verilog/hazardUnit.sv
verilog/proc.sv
tb/proc_assert.sv
tb/procTb.sv

// ==== tb/procTb.sv ====
// Testbench for the proc core
// Loads each program section from the input file, checks the writeback
// trace, err and halted, and bounds the run with a watchdog
`timescale 1ns/1ps
`default_nettype none

module procTb import procPkg::*; ();

   localparam int loadOverhead = 32;

   logic                    clk;
   logic                    rstN;
   logic                    progWrEn;
   logic                    progImem;
   logic [memAddrWidth-1:0] progAddr;
   logic [dataWidth-1:0]    progData;
   logic                    wbValid;
   logic [regAddrWidth-1:0] wbReg;
   logic [dataWidth-1:0]    wbData;
   logic                    halted;
   logic                    err;

   // Parsed sections with each one closed by an entry in the End queues
   logic [dataWidth-1:0]    instrQ [$];
   int                      instrEnd [$];
   logic [memAddrWidth-1:0] dataAddrQ [$];
   logic [dataWidth-1:0]    dataWordQ [$];
   int                      dataEnd [$];
   logic                    traceFromMem [$];
   logic [regAddrWidth-1:0] traceRegQ [$];
   logic [dataWidth-1:0]    traceValQ [$];
   int                      traceEnd [$];
   logic                    errExpect [$];

   logic [dataWidth-1:0] dmemCopy [dmemDepth];
   logic [31:0]          rngState;
   int                   watchdogCycles;
   int                   s;

   proc uut (
      .clk(clk), .rstN(rstN), .progWrEn(progWrEn), .progImem(progImem),
      .progAddr(progAddr), .progData(progData), .wbValid(wbValid), .wbReg(wbReg),
      .wbData(wbData), .halted(halted), .err(err));

   always #4 clk = ~clk;

   function automatic logic [31:0] lcgNext(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic stopWithFailure(input string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic parseInput();
      int          fd;
      int          n;
      string       tag;
      string       rest;
      logic [31:0] a;
      logic [31:0] b;
      fd = $fopen("tb/progInput.txt", "r");
      if (fd == 0) begin
         stopWithFailure("cannot open tb/progInput.txt");
      end else begin
         while ($fscanf(fd, "%s", tag) == 1) begin
            case (tag)
               "#": n = $fgets(rest, fd);
               "i": begin
                  n = $fscanf(fd, "%h", a);
                  instrQ.push_back(a[dataWidth-1:0]);
               end
               "d": begin
                  n = $fscanf(fd, "%h %h", a, b);
                  dataAddrQ.push_back(a[memAddrWidth-1:0]);
                  dataWordQ.push_back(b[dataWidth-1:0]);
               end
               "t", "l": begin
                  n = $fscanf(fd, "%h %h", a, b);
                  traceFromMem.push_back(tag == "l");
                  traceRegQ.push_back(a[regAddrWidth-1:0]);
                  traceValQ.push_back(b[dataWidth-1:0]);
               end
               "e": begin
                  n = $fscanf(fd, "%h", a);
                  errExpect.push_back(a[0]);
               end
               "end": begin
                  instrEnd.push_back(instrQ.size());
                  dataEnd.push_back(dataAddrQ.size());
                  traceEnd.push_back(traceRegQ.size());
               end
               default: stopWithFailure($sformatf("unknown tag %s in the input file", tag));
            endcase
         end
         $fclose(fd);
         assert (instrEnd.size() > 0 && errExpect.size() == instrEnd.size())
            else stopWithFailure("input file has no complete program section");
         // 40 cycles per program word plus reset and memory load time
         watchdogCycles = 40 * instrQ.size() + instrEnd.size() * (dmemDepth + loadOverhead);
      end
   endtask

   task automatic writeProgWord(input logic toImem, input int addr,
                                input logic [dataWidth-1:0] word);
      @(posedge clk);
      #1;
      progWrEn = 1'b1;
      progImem = toImem;
      progAddr = addr[memAddrWidth-1:0];
      progData = word;
   endtask

   task automatic loadSection(input int sec);
      int k;
      int a;
      @(posedge clk);
      #1;
      rstN = 1'b0;
      repeat (10) @(posedge clk);
      for (k = (sec == 0) ? 0 : instrEnd[sec-1]; k < instrEnd[sec]; k++)
         writeProgWord(1'b1, k - ((sec == 0) ? 0 : instrEnd[sec-1]), instrQ[k]);
      // Random background with the listed words laid over it
      for (a = 0; a < dmemDepth; a++) begin
         rngState    = lcgNext(rngState);
         dmemCopy[a] = rngState[31:16];
      end
      for (k = (sec == 0) ? 0 : dataEnd[sec-1]; k < dataEnd[sec]; k++)
         dmemCopy[dataAddrQ[k]] = dataWordQ[k];
      for (a = 0; a < dmemDepth; a++)
         writeProgWord(1'b0, a, dmemCopy[a]);
      @(posedge clk);
      #1;
      progWrEn = 1'b0;
      rstN     = 1'b1;
   endtask

   task automatic runSection(input int sec);
      int                   tIdx;
      int                   tLast;
      logic [dataWidth-1:0] expVal;
      tIdx  = (sec == 0) ? 0 : traceEnd[sec-1];
      tLast = traceEnd[sec];
      loadSection(sec);
      while (!halted) begin
         @(negedge clk);
         assert (uut.chk.errorCount == 0)
            else stopWithFailure("a bound pipeline assertion failed");
         if (wbValid) begin
            assert (tIdx < tLast)
               else stopWithFailure($sformatf("unexpected retire of r%0d with 0x%h", wbReg, wbData));
            expVal = traceFromMem[tIdx] ? dmemCopy[traceValQ[tIdx][memAddrWidth-1:0]]
                                        : traceValQ[tIdx];
            assert (wbReg == traceRegQ[tIdx])
               else stopWithFailure($sformatf("Error: wbReg 0x%h, expected 0x%h",
                                              wbReg, traceRegQ[tIdx]));
            assert (wbData == expVal)
               else stopWithFailure($sformatf("Error: wbData 0x%h, expected 0x%h",
                                              wbData, expVal));
            tIdx++;
         end
      end
      assert (tIdx == tLast)
         else stopWithFailure($sformatf("halted with %0d trace entries not retired", tLast - tIdx));
      assert (err == errExpect[sec])
         else stopWithFailure($sformatf("Error: err 0x%h, expected 0x%h", err, errExpect[sec]));
      // Nothing may retire once the core has halted
      repeat (4) begin
         @(negedge clk);
         assert (!wbValid)
            else stopWithFailure("a register write retired after halted");
      end
   endtask

   initial begin
      wait (watchdogCycles > 0);
      repeat (watchdogCycles) @(posedge clk);
      stopWithFailure("watchdog timeout, a program never reached halted");
   end

   initial begin
      clk            = 1'b0;
      rstN           = 1'b0;
      progWrEn       = 1'b0;
      progImem       = 1'b0;
      progAddr       = '0;
      progData       = '0;
      rngState       = 32'h8bbf;
      parseInput();
      for (s = 0; s < instrEnd.size(); s++)
         runSection(s);
      if (uut.chk.errorCount == 0) begin
         $display(">>> PASS");
         $finish;
      end else begin
         stopWithFailure("a bound pipeline assertion failed");
      end
   end

endmodule

`default_nettype wire

// ==== tb/proc_assert.sv ====
// Concurrent checks on the proc pipeline control
// Bubble after stall or redirect, sticky halted, wbValid under reset
`timescale 1ns/1ps
`default_nettype none

module procAssert (
   input logic clk,
   input logic rstN,
   input logic stall,
   input logic redirect,
   input logic dxValid,
   input logic halted,
   input logic wbValid
);

   int errorCount = 0;

   // Decode inserts a bubble behind a stall and behind a redirect
   bubbleAfterControl: assert property (@(posedge clk) disable iff (!rstN)
      (redirect || stall) |=> !dxValid)
      else begin
         $error("valid word in the decode-to-execute latch after stall or redirect");
         errorCount++;
      end

   haltedSticky: assert property (@(posedge clk) (rstN && halted) |=> halted)
      else begin
         $error("halted fell without reset");
         errorCount++;
      end

   noRetireInReset: assert property (@(posedge clk) !rstN |=> !wbValid)
      else begin
         $error("wbValid high during reset");
         errorCount++;
      end

endmodule

bind proc procAssert chk (
   .clk(clk), .rstN(rstN), .stall(stall), .redirect(redirect),
   .dxValid(dxBus.valid), .halted(halted), .wbValid(wbValid));

`default_nettype wire

// ==== tb/progInput.txt ====
# Tags: i <instr hex>, d <addr> <word>, e <err flag>, t <reg> <value>,
# l <reg> <addr> (value is the LCG data word at addr), end closes a section
# Independent ADD, SUB, AND, ADDI and LBI, then a word after HALT that must not retire
i C105 i C203 i C31C i C4F0 i 0800 i D954
i DB39 i DC7E i 421E i 0000 i C77F
t 1 0005 t 2 0003 t 3 001C t 4 FFF0
t 5 0008 t 6 0017 t 7 0010 t 0 0001
e 0
end
# Back-to-back dependent instructions
i C107 i 4141 i DA4C i DB2D i DB52 i 4498 i 0000
t 1 0007 t 2 0008 t 3 0010 t 3 0009 t 4 0008 t 4 0000
e 0
end
# LD from a random word, ST then LD, LD from a listed word
i C120 i 8943 i C35A i 8165 i 8985 i 89B0 i 0000
d 10 BEEF
t 1 0020 l 2 23 t 3 005A t 4 005A t 5 BEEF
e 0
end
# Taken BEEQZ, not-taken BNEZ, taken J
i C100 i 6102 i C211 i C322 i 6902 i C444
i C555 i 2002 i C666 i C777 i C212 i 0000
t 1 0000 t 4 0044 t 5 0055 t 2 0012
e 0
end
# Illegal opcode before HALT sets err
i C109 i F800 i 4141 i 0000
t 1 0009 t 2 000A
e 1
end

// ==== verilog/decode.sv ====
// Register file with write-through, control decode,
// illegal-opcode trap and the decode-to-execute latch
`timescale 1ns/1ps
`default_nettype none

module decode import procPkg::*; (
   input  logic                    clk,
   input  logic                    rstN,
   input  logic                    fdValid,
   input  logic [dataWidth-1:0]    fdInstr,
   input  logic [dataWidth-1:0]    fdPcInc,
   input  logic                    stall,
   input  logic                    redirect,
   mwIf.mwDst                      mw,
   dxIf.dxSrc                      dx,
   output logic                    haltSeen,
   output logic                    err,
   output logic                    rsUsed,
   output logic [regAddrWidth-1:0] rsIdx,
   output logic                    rtUsed,
   output logic [regAddrWidth-1:0] rtIdx
);

   instrWordT               iw;
   logic [dataWidth-1:0]    regs [2**regAddrWidth];
   logic [dataWidth-1:0]    aData;
   logic [dataWidth-1:0]    bData;
   logic [dataWidth-1:0]    imm;
   logic                    needRs;
   logic                    needRt;
   logic                    illegal;
   logic                    isHalt;
   aluOpT                   aluOp;
   logic                    useImm;
   logic                    memRead;
   logic                    memWrite;
   logic                    regWrite;
   logic [regAddrWidth-1:0] writeReg;
   logic                    isBranch;
   logic                    branchOnZero;
   logic                    isJump;
   logic                    mwWrites;

   assign iw = fdInstr;

   always_comb begin
      needRs       = 1'b0;
      needRt       = 1'b0;
      rsIdx        = iw.rType.rs;
      rtIdx        = iw.rType.rt;
      illegal      = 1'b0;
      isHalt       = 1'b0;
      aluOp        = aluAdd;
      useImm       = 1'b0;
      memRead      = 1'b0;
      memWrite     = 1'b0;
      regWrite     = 1'b0;
      writeReg     = iw.iType.rd;
      isBranch     = 1'b0;
      branchOnZero = 1'b0;
      isJump       = 1'b0;
      imm          = {{(dataWidth-5){iw.iType.imm[4]}}, iw.iType.imm};
      case (iw.rType.opcode)
         opHalt: isHalt = 1'b1;
         opNop: ;
         opAlu: begin
            // func 2'b11 has no register-register meaning
            if (iw.rType.func == 2'b11) begin
               illegal = 1'b1;
            end else begin
               needRs   = 1'b1;
               needRt   = 1'b1;
               aluOp    = aluOpT'(iw.rType.func);
               regWrite = 1'b1;
               writeReg = iw.rType.rd;
            end
         end
         opAddi, opLd: begin
            needRs   = 1'b1;
            useImm   = 1'b1;
            memRead  = (iw.rType.opcode == opLd);
            regWrite = 1'b1;
         end
         opSt: begin
            // ST keeps its data register in the rt position, read through port B
            needRs   = 1'b1;
            needRt   = 1'b1;
            useImm   = 1'b1;
            memWrite = 1'b1;
         end
         opLbi: begin
            aluOp    = aluPassB;
            useImm   = 1'b1;
            regWrite = 1'b1;
            writeReg = iw.iType.rs;
            imm      = {{(dataWidth-8){iw.jType.disp[7]}}, iw.jType.disp[7:0]};
         end
         opBeqz, opBnez: begin
            needRs       = 1'b1;
            isBranch     = 1'b1;
            branchOnZero = (iw.rType.opcode == opBeqz);
            imm          = {{(dataWidth-8){iw.jType.disp[7]}}, iw.jType.disp[7:0]};
         end
         opJ: begin
            isJump = 1'b1;
            imm    = {{(dataWidth-11){iw.jType.disp[10]}}, iw.jType.disp};
         end
         default: illegal = 1'b1;
      endcase
   end

   assign rsUsed   = fdValid && needRs;
   assign rtUsed   = fdValid && needRt;
   assign haltSeen = fdValid && isHalt;

   // Write in writeback shows up on a read in the same cycle
   assign mwWrites = mw.valid && mw.regWrite;
   assign aData    = (mwWrites && mw.writeReg == rsIdx) ? mw.result : regs[rsIdx];
   assign bData    = (mwWrites && mw.writeReg == rtIdx) ? mw.result : regs[rtIdx];

   always_ff @(posedge clk) begin
      if (mwWrites)
         regs[mw.writeReg] <= mw.result;
   end

   always_ff @(posedge clk) begin
      if (!rstN)
         err <= 1'b0;
      else if (fdValid && illegal)
         err <= 1'b1;
   end

   always_ff @(posedge clk) begin
      if (!rstN)
         dx.valid <= 1'b0;
      else if (redirect || stall)
         dx.valid <= 1'b0;
      else
         dx.valid <= fdValid;
   end

   always_ff @(posedge clk) begin
      dx.pcInc        <= fdPcInc;
      dx.aData        <= aData;
      dx.bData        <= bData;
      dx.imm          <= imm;
      dx.aluOp        <= aluOp;
      dx.useImm       <= useImm;
      dx.memRead      <= memRead;
      dx.memWrite     <= memWrite;
      dx.regWrite     <= regWrite;
      dx.writeReg     <= writeReg;
      dx.isBranch     <= isBranch;
      dx.branchOnZero <= branchOnZero;
      dx.isJump       <= isJump;
      dx.isHalt       <= isHalt;
   end

endmodule

`default_nettype wire

// ==== verilog/execute.sv ====
// Execute stage: ALU, branch and jump resolution,
// and the execute-to-memory latch
`timescale 1ns/1ps
`default_nettype none

module execute import procPkg::*; (
   input  logic                 clk,
   input  logic                 rstN,
   dxIf.dxDst                   dx,
   xmIf.xmSrc                   xm,
   output logic                 redirect,
   output logic [dataWidth-1:0] redirectPc
);

   logic [dataWidth-1:0] aluB;
   logic [dataWidth-1:0] aluOut;
   logic                 aZero;
   logic                 branchTaken;

   assign aluB = dx.useImm ? dx.imm : dx.bData;

   always_comb begin
      case (dx.aluOp)
         aluAdd:  aluOut = dx.aData + aluB;
         aluSub:  aluOut = dx.aData - aluB;
         aluAnd:  aluOut = dx.aData & aluB;
         default: aluOut = aluB;   // LBI
      endcase
   end

   // BEQZ takes on zero, BNEZ on nonzero
   assign aZero       = (dx.aData == '0);
   assign branchTaken = dx.isBranch && (aZero == dx.branchOnZero);
   assign redirect    = dx.valid && (dx.isJump || branchTaken);
   assign redirectPc  = dx.pcInc + dx.imm;

   always_ff @(posedge clk) begin
      if (!rstN)
         xm.valid <= 1'b0;
      else
         xm.valid <= dx.valid;
   end

   always_ff @(posedge clk) begin
      xm.aluOut    <= aluOut;
      xm.storeData <= dx.bData;
      xm.memRead   <= dx.memRead;
      xm.memWrite  <= dx.memWrite;
      xm.regWrite  <= dx.regWrite;
      xm.writeReg  <= dx.writeReg;
      xm.isHalt    <= dx.isHalt;
   end

endmodule

`default_nettype wire

// ==== verilog/fetch.sv ====
// Fetch stage: program counter, instruction memory,
// and the fetch-to-decode latch
`timescale 1ns/1ps
`default_nettype none

module fetch import procPkg::*; (
   input  logic                    clk,
   input  logic                    rstN,
   input  logic                    stall,
   input  logic                    redirect,
   input  logic [dataWidth-1:0]    redirectPc,
   input  logic                    haltSeen,
   input  logic                    progWrEn,
   input  logic                    progImem,
   input  logic [memAddrWidth-1:0] progAddr,
   input  logic [dataWidth-1:0]    progData,
   output logic                    fdValid,
   output logic [dataWidth-1:0]    fdInstr,
   output logic [dataWidth-1:0]    fdPcInc
);

   logic [dataWidth-1:0] imem [imemDepth];
   logic [dataWidth-1:0] pc;
   logic [dataWidth-1:0] pcInc;
   logic                 stopped;

   assign pcInc = pc + 1'b1;

   always_ff @(posedge clk) begin
      if (progWrEn && progImem)
         imem[progAddr] <= progData;
   end

   // Redirect wins over stall; a decoded HALT freezes the pc for good
   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc      <= '0;
         fdValid <= 1'b0;
         stopped <= 1'b0;
      end else if (redirect) begin
         pc      <= redirectPc;
         fdValid <= 1'b0;
      end else if (!stall) begin
         if (stopped || haltSeen) begin
            fdValid <= 1'b0;
            stopped <= 1'b1;
         end else begin
            pc      <= pcInc;
            fdValid <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         fdInstr <= imem[pc[memAddrWidth-1:0]];
         fdPcInc <= pcInc;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/hazardUnit.sv ====
// Read-after-write hazard detection for the word in decode
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import procPkg::*; (
   input  logic                    rsUsed,
   input  logic [regAddrWidth-1:0] rsIdx,
   input  logic                    rtUsed,
   input  logic [regAddrWidth-1:0] rtIdx,
   dxIf.dxDst                      dx,
   xmIf.xmDst                      xm,
   output logic                    stall
);

   logic dxWrites;
   logic xmWrites;
   logic rsHazard;
   logic rtHazard;

   assign dxWrites = dx.valid && dx.regWrite;
   assign xmWrites = xm.valid && xm.regWrite;

   // Writeback needs no check since the register file passes it through
   assign rsHazard = rsUsed && ((dxWrites && dx.writeReg == rsIdx) ||
                                (xmWrites && xm.writeReg == rsIdx));
   assign rtHazard = rtUsed && ((dxWrites && dx.writeReg == rtIdx) ||
                                (xmWrites && xm.writeReg == rtIdx));

   assign stall = rsHazard || rtHazard;

endmodule

`default_nettype wire

// ==== verilog/memory.sv ====
// Memory stage: data memory, writeback result select,
// and the memory-to-writeback latch
`timescale 1ns/1ps
`default_nettype none

module memory import procPkg::*; (
   input  logic                    clk,
   input  logic                    rstN,
   xmIf.xmDst                      xm,
   input  logic                    progWrEn,
   input  logic                    progImem,
   input  logic [memAddrWidth-1:0] progAddr,
   input  logic [dataWidth-1:0]    progData,
   mwIf.mwSrc                      mw
);

   logic [dataWidth-1:0]    dmem [dmemDepth];
   logic [memAddrWidth-1:0] dAddr;
   logic [dataWidth-1:0]    result;

   // Word addressed, upper address bits ignored
   assign dAddr = xm.aluOut[memAddrWidth-1:0];

   always_ff @(posedge clk) begin
      if (progWrEn && !progImem)
         dmem[progAddr] <= progData;
      else if (xm.valid && xm.memWrite)
         dmem[dAddr] <= xm.storeData;
   end

   assign result = xm.memRead ? dmem[dAddr] : xm.aluOut;

   always_ff @(posedge clk) begin
      if (!rstN)
         mw.valid <= 1'b0;
      else
         mw.valid <= xm.valid;
   end

   always_ff @(posedge clk) begin
      mw.result   <= result;
      mw.regWrite <= xm.regWrite;
      mw.writeReg <= xm.writeReg;
      mw.isHalt   <= xm.isHalt;
   end

endmodule

`default_nettype wire

// ==== verilog/proc.sv ====
// Top of the five-stage proc core
// Stage wiring, program load port, writeback trace, halted flag
`timescale 1ns/1ps
`default_nettype none

module proc import procPkg::*; (
   input  logic                    clk,
   input  logic                    rstN,
   input  logic                    progWrEn,
   input  logic                    progImem,
   input  logic [memAddrWidth-1:0] progAddr,
   input  logic [dataWidth-1:0]    progData,
   output logic                    wbValid,
   output logic [regAddrWidth-1:0] wbReg,
   output logic [dataWidth-1:0]    wbData,
   output logic                    halted,
   output logic                    err
);

   logic                    fdValid;
   logic [dataWidth-1:0]    fdInstr;
   logic [dataWidth-1:0]    fdPcInc;
   logic                    stall;
   logic                    redirect;
   logic [dataWidth-1:0]    redirectPc;
   logic                    haltSeen;
   logic                    rsUsed;
   logic [regAddrWidth-1:0] rsIdx;
   logic                    rtUsed;
   logic [regAddrWidth-1:0] rtIdx;

   dxIf dxBus ();
   xmIf xmBus ();
   mwIf mwBus ();

   fetch fetchStage (
      .clk(clk), .rstN(rstN), .stall(stall), .redirect(redirect),
      .redirectPc(redirectPc), .haltSeen(haltSeen), .progWrEn(progWrEn),
      .progImem(progImem), .progAddr(progAddr), .progData(progData),
      .fdValid(fdValid), .fdInstr(fdInstr), .fdPcInc(fdPcInc));

   decode decodeStage (
      .clk(clk), .rstN(rstN), .fdValid(fdValid), .fdInstr(fdInstr),
      .fdPcInc(fdPcInc), .stall(stall), .redirect(redirect),
      .mw(mwBus.mwDst), .dx(dxBus.dxSrc), .haltSeen(haltSeen), .err(err),
      .rsUsed(rsUsed), .rsIdx(rsIdx), .rtUsed(rtUsed), .rtIdx(rtIdx));

   hazardUnit hazard (
      .rsUsed(rsUsed), .rsIdx(rsIdx), .rtUsed(rtUsed), .rtIdx(rtIdx),
      .dx(dxBus.dxDst), .xm(xmBus.xmDst), .stall(stall));

   execute executeStage (
      .clk(clk), .rstN(rstN), .dx(dxBus.dxDst), .xm(xmBus.xmSrc),
      .redirect(redirect), .redirectPc(redirectPc));

   memory memoryStage (
      .clk(clk), .rstN(rstN), .xm(xmBus.xmDst), .progWrEn(progWrEn),
      .progImem(progImem), .progAddr(progAddr), .progData(progData),
      .mw(mwBus.mwSrc));

   // Trace of every retired register write
   assign wbValid = mwBus.valid && mwBus.regWrite;
   assign wbReg   = mwBus.writeReg;
   assign wbData  = mwBus.result;

   always_ff @(posedge clk) begin
      if (!rstN)
         halted <= 1'b0;
      else if (mwBus.valid && mwBus.isHalt)
         halted <= 1'b1;
   end

endmodule

`default_nettype wire

// ==== verilog/procPkg.sv ====
// Shared widths and memory depths for the proc core
// Opcode and ALU operation encodings
// Instruction word formats and the decoding union
`default_nettype none

package procPkg;

   localparam int dataWidth    = 16;
   localparam int regAddrWidth = 3;
   localparam int imemDepth    = 256;
   localparam int dmemDepth    = 256;
   localparam int memAddrWidth = 8;

   typedef enum logic [4:0] {
      opHalt = 5'b00000,
      opNop  = 5'b00001,
      opJ    = 5'b00100,
      opAddi = 5'b01000,
      opBeqz = 5'b01100,
      opBnez = 5'b01101,
      opSt   = 5'b10000,
      opLd   = 5'b10001,
      opLbi  = 5'b11000,
      opAlu  = 5'b11011   // ADD, SUB, AND chosen by func
   } opcodeT;

   // Also the func field encoding of the register-register group
   typedef enum logic [1:0] {
      aluAdd   = 2'b00,
      aluSub   = 2'b01,
      aluAnd   = 2'b10,
      aluPassB = 2'b11
   } aluOpT;

   typedef struct packed {
      opcodeT                  opcode;
      logic [regAddrWidth-1:0] rs;
      logic [regAddrWidth-1:0] rt;
      logic [regAddrWidth-1:0] rd;
      logic [1:0]              func;
   } rTypeT;

   typedef struct packed {
      opcodeT                  opcode;
      logic [regAddrWidth-1:0] rs;
      logic [regAddrWidth-1:0] rd;
      logic [4:0]              imm;
   } iTypeT;

   // Branches and LBI take rs from disp[10:8] and an 8-bit field below it
   typedef struct packed {
      opcodeT      opcode;
      logic [10:0] disp;
   } jTypeT;

   typedef union packed {
      rTypeT rType;
      iTypeT iType;
      jTypeT jType;
   } instrWordT;

endpackage

`default_nettype wire

// ==== verilog/stageIf.sv ====
// Pipeline latch interfaces
// dxIf decode to execute, xmIf execute to memory, mwIf memory to writeback
`timescale 1ns/1ps
`default_nettype none

interface dxIf import procPkg::*; ();
   logic                    valid;
   logic [dataWidth-1:0]    pcInc;
   logic [dataWidth-1:0]    aData;
   logic [dataWidth-1:0]    bData;
   logic [dataWidth-1:0]    imm;
   aluOpT                   aluOp;
   logic                    useImm;
   logic                    memRead;
   logic                    memWrite;
   logic                    regWrite;
   logic [regAddrWidth-1:0] writeReg;
   logic                    isBranch;
   logic                    branchOnZero;
   logic                    isJump;
   logic                    isHalt;

   modport dxSrc (output valid, pcInc, aData, bData, imm, aluOp, useImm, memRead,
                  memWrite, regWrite, writeReg, isBranch, branchOnZero, isJump, isHalt);
   modport dxDst (input valid, pcInc, aData, bData, imm, aluOp, useImm, memRead,
                  memWrite, regWrite, writeReg, isBranch, branchOnZero, isJump, isHalt);
endinterface

interface xmIf import procPkg::*; ();
   logic                    valid;
   logic [dataWidth-1:0]    aluOut;
   logic [dataWidth-1:0]    storeData;
   logic                    memRead;
   logic                    memWrite;
   logic                    regWrite;
   logic [regAddrWidth-1:0] writeReg;
   logic                    isHalt;

   modport xmSrc (output valid, aluOut, storeData, memRead, memWrite, regWrite,
                  writeReg, isHalt);
   modport xmDst (input valid, aluOut, storeData, memRead, memWrite, regWrite,
                  writeReg, isHalt);
endinterface

interface mwIf import procPkg::*; ();
   logic                    valid;
   logic [dataWidth-1:0]    result;
   logic                    regWrite;
   logic [regAddrWidth-1:0] writeReg;
   logic                    isHalt;

   modport mwSrc (output valid, result, regWrite, writeReg, isHalt);
   modport mwDst (input valid, result, regWrite, writeReg, isHalt);
endinterface

`default_nettype wire
